// ==== tb.f ====
+incdir+design
+incdir+tb
design/hazard_pkg.sv
design/dest_track_if.sv
design/fwd_ctrl.sv
design/stall_detect.sv
design/id_branch_unit.sv
design/ex_branch_judge.sv
design/flush_counter.sv
design/hazard_top.sv
tb/tb_hazard_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the hazard unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_hazard_top -f tb.f --Mdir obj_dir -o tb_hazard_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_hazard_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb/hazard_vectors.svh ====
//****************************
// hazard unit test rows, stimulus and expected results
//****************************
`ifndef HAZARD_VECTORS_SVH
`define HAZARD_VECTORS_SVH

typedef struct packed {
    branch_op_e id_op;                    // ID stage
    reg_addr_t  id_rs1, id_rs2;
    logic       id_st;                    // ID instr is a store
    word_t      imm;                      // B or J immediate, by id_op
    logic       make_eq;                  // force equal ID compare words
    reg_addr_t  ex_rs1, ex_rs2, ex_rd;    // EX stage
    logic       ex_w, ex_ld;
    branch_op_e ex_op;
    logic       cmp;
    reg_addr_t  mem_rd;                   // MEM stage
    logic       mem_w, mem_ld;
    reg_addr_t  wb_rd;                    // WB stage
    logic       wb_w;
    fwd_sel_e   e_fa, e_fb, e_ida, e_idb; // expected selects
    logic       e_stall;
    logic [1:0] e_redir;
    logic [1:0] e_tgt;
} vec_t;

localparam logic [1:0] R_NO  = 2'd0;  // no redirect
localparam logic [1:0] R_YES = 2'd1;
localparam logic [1:0] R_CMP = 2'd2;  // taken if beq/bne compare holds
localparam logic [1:0] T_NONE = 2'd0; // target not checked
localparam logic [1:0] T_ID   = 2'd1; // pc + imm
localparam logic [1:0] T_EX   = 2'd2; // datapath target
localparam int NUM_VECS = 15;

vec_t vecs [NUM_VECS];

task automatic load_vectors();
    // line 1: id_op id_rs1 id_rs2 store imm make_eq
    // line 2: ex_rs1 ex_rs2 ex_rd ex_w ex_ld ex_op cmp, mem_rd w ld, wb_rd w
    // line 3: fwd_a fwd_b id_a id_b stall redirect target
    vecs[0]  = '{BR_NONE, '0, '0, '0, '0, '0,
                 5'd5, 5'd6, '0, '0, '0, BR_NONE, '0, 5'd5, '1, '0, 5'd5, '1,
                 FWD_MEM, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_NO, T_NONE};
    vecs[1]  = '{BR_NONE, '0, '0, '0, '0, '0,
                 5'd7, 5'd9, '0, '0, '0, BR_NONE, '0, 5'd8, '1, '0, 5'd9, '1,
                 FWD_NONE, FWD_WB, FWD_NONE, FWD_NONE, '0, R_NO, T_NONE};
    vecs[2]  = '{BR_NONE, '0, '0, '0, '0, '0,        // x0 and write off
                 '0, 5'd4, '0, '0, '0, BR_NONE, '0, '0, '1, '0, 5'd4, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_NO, T_NONE};
    vecs[3]  = '{BR_NONE, 5'd1, 5'd10, '0, '0, '0,   // load-use on rs2
                 '0, '0, 5'd10, '1, '1, BR_NONE, '0, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '1, R_NO, T_NONE};
    vecs[4]  = '{BR_NONE, 5'd1, 5'd10, '1, '0, '0,   // store data only
                 '0, '0, 5'd10, '1, '1, BR_NONE, '0, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_NO, T_NONE};
    vecs[5]  = '{BR_BEQ, 5'd11, 5'd12, '0, 32'h10, '1,
                 '0, '0, '0, '0, '0, BR_NONE, '0, 5'd11, '1, '0, 5'd12, '1,
                 FWD_NONE, FWD_NONE, FWD_MEM, FWD_WB, '0, R_CMP, T_ID};
    vecs[6]  = '{BR_BEQ, 5'd11, 5'd12, '0, 32'hffff_fff8, '0,
                 '0, '0, '0, '0, '0, BR_NONE, '0, 5'd11, '1, '0, 5'd12, '1,
                 FWD_NONE, FWD_NONE, FWD_MEM, FWD_WB, '0, R_CMP, T_ID};
    vecs[7]  = '{BR_BNE, 5'd13, 5'd14, '0, 32'h0000_0ffe, '0,
                 '0, '0, '0, '0, '0, BR_NONE, '0, 5'd14, '1, '0, 5'd13, '1,
                 FWD_NONE, FWD_NONE, FWD_WB, FWD_MEM, '0, R_CMP, T_ID};
    vecs[8]  = '{BR_BNE, 5'd15, 5'd16, '0, 32'hffff_f000, '1,
                 '0, '0, '0, '0, '0, BR_NONE, '0, 5'd15, '1, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_MEM, FWD_NONE, '0, R_CMP, T_ID};
    vecs[9]  = '{BR_BEQ, 5'd17, 5'd18, '0, 32'h20, '1,  // alu result still in EX
                 '0, '0, 5'd17, '1, '0, BR_NONE, '0, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '1, R_NO, T_ID};
    vecs[10] = '{BR_BEQ, 5'd19, 5'd20, '0, 32'h40, '1,  // load still in MEM
                 '0, '0, '0, '0, '0, BR_NONE, '0, 5'd20, '1, '1, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_MEM, '1, R_NO, T_ID};
    vecs[11] = '{BR_JAL, '0, '0, '0, 32'h0001_2344, '0,
                 '0, '0, '0, '0, '0, BR_NONE, '0, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_YES, T_ID};
    vecs[12] = '{BR_JAL, '0, '0, '0, 32'hfff0_0000, '0,
                 '0, '0, '0, '0, '0, BR_NONE, '0, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_YES, T_ID};
    vecs[13] = '{BR_JAL, '0, '0, '0, 32'h800, '0,       // EX wins over ID
                 '0, '0, '0, '0, '0, BR_BLT, '1, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_YES, T_EX};
    vecs[14] = '{BR_NONE, '0, '0, '0, '0, '0,
                 '0, '0, '0, '0, '0, BR_BGEU, '1, '0, '0, '0, '0, '0,
                 FWD_NONE, FWD_NONE, FWD_NONE, FWD_NONE, '0, R_NO, T_NONE};
endtask

`endif

// ==== tb/tb_hazard_top.sv ====
//****************************
// testbench for the hazard and branch resolve unit
//****************************
`timescale 1ns/1ns
`include "hazard_macros.svh"

module tb_hazard_top import hazard_pkg::*; ();

    logic       clk = 1'b0;
    logic       arst_n_i;
    word_t      id_inst_i, id_pc_i, rs1_data_i, rs2_data_i;
    reg_addr_t  id_rs1_i, id_rs2_i;
    logic       id_is_store_i;
    branch_op_e id_branch_op_i;
    reg_addr_t  ex_rs1_i, ex_rs2_i, ex_rd_i;
    logic       ex_reg_w_i, ex_mem_read_i, compare_res_i;
    branch_op_e ex_branch_op_i;
    word_t      ex_target_i;
    reg_addr_t  mem_rd_i;
    logic       mem_reg_w_i, mem_mem_read_i;
    word_t      mem_fwd_data_i;
    reg_addr_t  wb_rd_i;
    logic       wb_reg_w_i;
    word_t      wb_fwd_data_i;
    fwd_sel_e   fwd_a_o, fwd_b_o;
    logic       stall_o, redirect_o, flush_o;
    word_t      target_o;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          row_err = 0;    // mismatches in current test
    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'hd2af;
    int          row_idx;

    `include "hazard_vectors.svh"

    // drain, one redirect cycle, flush window; two sequences
    localparam int FLUSH_SEQ_CYCLES = 2 * (2 * `EX_FLUSH_CYCLES + 6);
    localparam int TIMEOUT_CYCLES   = (NUM_VECS + FLUSH_SEQ_CYCLES) * 2 + 20;

    hazard_top u_dut (.*);

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rv32i B-type, rs fields left zero
    function automatic word_t enc_b(input word_t imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // rv32i J-type, rd = x0
    function automatic word_t enc_j(input word_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    endfunction

    // word an operand sees for a given source
    function automatic word_t pick_word(input fwd_sel_e sel, input word_t rf,
                                        input word_t mem, input word_t wb);
        if (sel == FWD_MEM)
            return mem;
        else if (sel == FWD_WB)
            return wb;
        return rf;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_err++;
            $display("** Error %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (row_err == 0)
            $display("%s: ok", name);
        else
            $display("%s: %0d mismatches", name, row_err);
        row_err = 0;
    endtask

    task automatic drive_idle();
        id_inst_i      <= '0;
        id_pc_i        <= '0;
        id_rs1_i       <= '0;
        id_rs2_i       <= '0;
        id_is_store_i  <= 1'b0;
        id_branch_op_i <= BR_NONE;
        rs1_data_i     <= '0;
        rs2_data_i     <= '0;
        ex_rs1_i       <= '0;
        ex_rs2_i       <= '0;
        ex_rd_i        <= '0;
        ex_reg_w_i     <= 1'b0;
        ex_mem_read_i  <= 1'b0;
        ex_branch_op_i <= BR_NONE;
        compare_res_i  <= 1'b0;
        ex_target_i    <= '0;
        mem_rd_i       <= '0;
        mem_reg_w_i    <= 1'b0;
        mem_mem_read_i <= 1'b0;
        mem_fwd_data_i <= '0;
        wb_rd_i        <= '0;
        wb_reg_w_i     <= 1'b0;
        wb_fwd_data_i  <= '0;
    endtask

    task automatic run_row(input int idx);
        vec_t       v;
        branch_op_e op;
        word_t      d_rs1, d_rs2, d_mem, d_wb, pc, ex_tgt, inst;
        word_t      a_word, b_word, exp_tgt;
        logic       exp_redir;
        v      = vecs[idx];
        op     = v.id_op;
        d_rs1  = next_rand();
        d_rs2  = next_rand();
        d_mem  = next_rand();
        d_wb   = next_rand();
        pc     = next_rand() & 32'hffff_fffc;  // word aligned
        ex_tgt = next_rand() & 32'hffff_fffc;
        if (v.make_eq) begin
            a_word = pick_word(v.e_ida, d_rs1, d_mem, d_wb);
            if (v.e_idb == FWD_MEM)
                d_mem = a_word;
            else if (v.e_idb == FWD_WB)
                d_wb = a_word;
            else
                d_rs2 = a_word;
        end
        a_word = pick_word(v.e_ida, d_rs1, d_mem, d_wb);
        b_word = pick_word(v.e_idb, d_rs2, d_mem, d_wb);
        inst   = (op == BR_JAL) ? enc_j(v.imm) : enc_b(v.imm);
        if (v.e_redir == R_YES)
            exp_redir = 1'b1;
        else if (v.e_redir == R_CMP)
            exp_redir = (op == BR_BEQ) ? (a_word == b_word) : (a_word != b_word);
        else
            exp_redir = 1'b0;
        exp_tgt = (v.e_tgt == T_EX) ? ex_tgt : pc + v.imm;

        @(posedge clk);
        id_inst_i      <= inst;
        id_pc_i        <= pc;
        id_rs1_i       <= v.id_rs1;
        id_rs2_i       <= v.id_rs2;
        id_is_store_i  <= v.id_st;
        id_branch_op_i <= v.id_op;
        rs1_data_i     <= d_rs1;
        rs2_data_i     <= d_rs2;
        ex_rs1_i       <= v.ex_rs1;
        ex_rs2_i       <= v.ex_rs2;
        ex_rd_i        <= v.ex_rd;
        ex_reg_w_i     <= v.ex_w;
        ex_mem_read_i  <= v.ex_ld;
        ex_branch_op_i <= v.ex_op;
        compare_res_i  <= v.cmp;
        ex_target_i    <= ex_tgt;
        mem_rd_i       <= v.mem_rd;
        mem_reg_w_i    <= v.mem_w;
        mem_mem_read_i <= v.mem_ld;
        mem_fwd_data_i <= d_mem;
        wb_rd_i        <= v.wb_rd;
        wb_reg_w_i     <= v.wb_w;
        wb_fwd_data_i  <= d_wb;

        @(negedge clk);  // combinational outputs settled
        check_val("fwd_a_o", 32'(fwd_a_o), 32'(v.e_fa));
        check_val("fwd_b_o", 32'(fwd_b_o), 32'(v.e_fb));
        check_val("stall_o", 32'(stall_o), 32'(v.e_stall));
        check_val("redirect_o", 32'(redirect_o), 32'(exp_redir));
        if (v.e_tgt != T_NONE)
            check_val("target_o", target_o, exp_tgt);
        end_test($sformatf("row %0d %s", idx, op.name()));
    endtask

    task automatic flush_seq(input logic from_ex, input int exp_len, input string name);
        int i;
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        while (flush_o) begin
            @(negedge clk);  // let earlier flush drain
        end
        @(posedge clk);
        if (from_ex)
            ex_branch_op_i <= BR_JALR;
        else
            id_branch_op_i <= BR_JAL;
        @(negedge clk);
        check_val("redirect_o", 32'(redirect_o), 32'd1);
        check_val("flush_o", 32'(flush_o), 32'd0);
        @(posedge clk);
        drive_idle();
        for (i = 0; i < exp_len + 2; i++) begin
            @(negedge clk);
            check_val("flush_o", 32'(flush_o), (i < exp_len) ? 32'd1 : 32'd0);
        end
        end_test(name);
    endtask

    initial begin
        drive_idle();
        arst_n_i <= 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_val("flush_o", 32'(flush_o), 32'd0);
        check_val("stall_o", 32'(stall_o), 32'd0);
        check_val("redirect_o", 32'(redirect_o), 32'd0);
        end_test("after reset");
        for (row_idx = 0; row_idx < NUM_VECS; row_idx++) begin
            run_row(row_idx);
        end
        flush_seq(1'b0, `ID_FLUSH_CYCLES, "id redirect flush");
        flush_seq(1'b1, `EX_FLUSH_CYCLES, "ex redirect flush");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== design/hazard_top.sv ====
//****************************
// hazard and branch resolve unit, rv32i 5-stage
//****************************
`timescale 1ns/1ns

module hazard_top import hazard_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    // ID stage
    input  word_t      id_inst_i,
    input  word_t      id_pc_i,
    input  reg_addr_t  id_rs1_i,
    input  reg_addr_t  id_rs2_i,
    input  logic       id_is_store_i,
    input  branch_op_e id_branch_op_i,
    input  word_t      rs1_data_i,
    input  word_t      rs2_data_i,
    // EX stage
    input  reg_addr_t  ex_rs1_i,
    input  reg_addr_t  ex_rs2_i,
    input  reg_addr_t  ex_rd_i,
    input  logic       ex_reg_w_i,
    input  logic       ex_mem_read_i,
    input  branch_op_e ex_branch_op_i,
    input  logic       compare_res_i,
    input  word_t      ex_target_i,
    // MEM stage
    input  reg_addr_t  mem_rd_i,
    input  logic       mem_reg_w_i,
    input  logic       mem_mem_read_i,
    input  word_t      mem_fwd_data_i,
    // WB stage
    input  reg_addr_t  wb_rd_i,
    input  logic       wb_reg_w_i,
    input  word_t      wb_fwd_data_i,
    // results
    output fwd_sel_e   fwd_a_o,
    output fwd_sel_e   fwd_b_o,
    output logic       stall_o,
    output logic       redirect_o,
    output word_t      target_o,
    output logic       flush_o
);

    fwd_sel_e fwd_id_a;
    fwd_sel_e fwd_id_b;
    logic     id_redirect;
    word_t    id_target;
    logic     ex_redirect;
    word_t    ex_target;

    dest_track_if dest ();

    // pipeline regs onto the tracking bus
    assign dest.ex_rd        = ex_rd_i;
    assign dest.ex_reg_w     = ex_reg_w_i;
    assign dest.ex_mem_read  = ex_mem_read_i;
    assign dest.mem_rd       = mem_rd_i;
    assign dest.mem_reg_w    = mem_reg_w_i;
    assign dest.mem_mem_read = mem_mem_read_i;
    assign dest.wb_rd        = wb_rd_i;
    assign dest.wb_reg_w     = wb_reg_w_i;

    fwd_ctrl u_fwd_ctrl (
        .dest       (dest.dst),
        .id_rs1_i   (id_rs1_i),
        .id_rs2_i   (id_rs2_i),
        .ex_rs1_i   (ex_rs1_i),
        .ex_rs2_i   (ex_rs2_i),
        .fwd_a_o    (fwd_a_o),
        .fwd_b_o    (fwd_b_o),
        .fwd_id_a_o (fwd_id_a),
        .fwd_id_b_o (fwd_id_b)
    );

    stall_detect u_stall_detect (
        .dest           (dest.dst),
        .id_rs1_i       (id_rs1_i),
        .id_rs2_i       (id_rs2_i),
        .id_is_store_i  (id_is_store_i),
        .id_branch_op_i (id_branch_op_i),
        .stall_o        (stall_o)
    );

    id_branch_unit u_id_branch_unit (
        .id_inst_i      (id_inst_i),
        .id_pc_i        (id_pc_i),
        .id_branch_op_i (id_branch_op_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .mem_fwd_data_i (mem_fwd_data_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .fwd_id_a_i     (fwd_id_a),
        .fwd_id_b_i     (fwd_id_b),
        .stall_i        (stall_o),
        .id_redirect_o  (id_redirect),
        .id_target_o    (id_target)
    );

    ex_branch_judge u_ex_branch_judge (
        .ex_branch_op_i (ex_branch_op_i),
        .compare_res_i  (compare_res_i),
        .ex_target_i    (ex_target_i),
        .ex_redirect_o  (ex_redirect),
        .ex_target_o    (ex_target)
    );

    // EX instr is older, so it wins
    assign redirect_o = ex_redirect || id_redirect;
    assign target_o   = ex_redirect ? ex_target : id_target;

    flush_counter u_flush_counter (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .redirect_i (redirect_o),
        .from_ex_i  (ex_redirect),  // selects the longer flush
        .flush_o    (flush_o)
    );

endmodule

// ==== design/flush_counter.sv ====
//****************************
// flush length after a redirect
//****************************
`timescale 1ns/1ns
`include "hazard_macros.svh"

module flush_counter import hazard_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    input  logic redirect_i,
    input  logic from_ex_i,    // redirect came from EX
    output logic flush_o
);

    localparam int CNT_W = $clog2(`EX_FLUSH_CYCLES + 1);

    logic [CNT_W-1:0] cnt;     // flush cycles left
    logic [CNT_W-1:0] load_val;

    // EX redirect leaves one more wrong-path instr in the pipe
    assign load_val = from_ex_i ? CNT_W'(`EX_FLUSH_CYCLES) : CNT_W'(`ID_FLUSH_CYCLES);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt <= '0;
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);  // later redirects are wrong-path and ignored
        end else if (redirect_i) begin
            cnt <= load_val;
        end
    end

    assign flush_o = (cnt != '0);

endmodule

// ==== design/ex_branch_judge.sv ====
//****************************
// EX stage late branch and jalr decide
//****************************
`timescale 1ns/1ns

module ex_branch_judge import hazard_pkg::*; (
    input  branch_op_e ex_branch_op_i,
    input  logic       compare_res_i,   // rs1 < rs2, signedness from op
    input  word_t      ex_target_i,     // computed by datapath
    output logic       ex_redirect_o,
    output word_t      ex_target_o
);

    always_comb begin
        case (ex_branch_op_i)
            BR_BLT,
            BR_BLTU: ex_redirect_o = compare_res_i;   // a < b
            BR_BGE,
            BR_BGEU: ex_redirect_o = !compare_res_i;  // a >= b
            BR_JALR: ex_redirect_o = 1'b1;
            default: ex_redirect_o = 1'b0;  // beq, bne, jal done in ID
        endcase
    end

    assign ex_target_o = ex_target_i;

endmodule

// ==== design/id_branch_unit.sv ====
//****************************
// ID stage jal and beq/bne resolve
//****************************
`timescale 1ns/1ns

module id_branch_unit import hazard_pkg::*; (
    input  word_t      id_inst_i,
    input  word_t      id_pc_i,
    input  branch_op_e id_branch_op_i,
    input  word_t      rs1_data_i,       // register file reads
    input  word_t      rs2_data_i,
    input  word_t      mem_fwd_data_i,   // alu result in EX/MEM
    input  word_t      wb_fwd_data_i,    // write-back data
    input  fwd_sel_e   fwd_id_a_i,
    input  fwd_sel_e   fwd_id_b_i,
    input  logic       stall_i,
    output logic       id_redirect_o,
    output word_t      id_target_o
);

    word_t opnd_a;
    word_t opnd_b;
    word_t imm_j;
    word_t imm_b;
    word_t imm_sel;
    logic  is_equal;
    logic  taken;

    // three-way operand pick
    function automatic word_t sel_opnd(
        input fwd_sel_e sel,
        input word_t    rf_data,
        input word_t    mem_data,
        input word_t    wb_data
    );
        word_t res;
        case (sel)
            FWD_MEM: res = mem_data;
            FWD_WB:  res = wb_data;
            default: res = rf_data;
        endcase
        return res;
    endfunction

    assign opnd_a = sel_opnd(fwd_id_a_i, rs1_data_i, mem_fwd_data_i, wb_fwd_data_i);
    assign opnd_b = sel_opnd(fwd_id_b_i, rs2_data_i, mem_fwd_data_i, wb_fwd_data_i);

    // immediates, bit 0 always zero
    assign imm_j = {{12{id_inst_i[31]}}, id_inst_i[19:12], id_inst_i[20],
                    id_inst_i[30:21], 1'b0};
    assign imm_b = {{20{id_inst_i[31]}}, id_inst_i[7], id_inst_i[30:25],
                    id_inst_i[11:8], 1'b0};

    assign imm_sel     = (id_branch_op_i == BR_JAL) ? imm_j : imm_b;
    assign id_target_o = id_pc_i + imm_sel;  // pc-relative target

    assign is_equal = (opnd_a == opnd_b);

    always_comb begin
        case (id_branch_op_i)
            BR_JAL:  taken = 1'b1;
            BR_BEQ:  taken = is_equal;
            BR_BNE:  taken = !is_equal;
            default: taken = 1'b0;    // resolved later in EX
        endcase
    end

    // operands not ready while stalled
    assign id_redirect_o = taken && !stall_i;

endmodule

// ==== design/stall_detect.sv ====
//****************************
// load-use and branch-load stall
//****************************
`timescale 1ns/1ns

module stall_detect import hazard_pkg::*; (
    dest_track_if.dst dest,
    input  reg_addr_t  id_rs1_i,
    input  reg_addr_t  id_rs2_i,
    input  logic       id_is_store_i,   // rs2 of a store is only data
    input  branch_op_e id_branch_op_i,
    output logic       stall_o
);

    logic ex_wr_valid;   // EX writes a real reg
    logic ex_load;
    logic mem_load;
    logic ex_hit_rs1;
    logic ex_hit_rs2;
    logic mem_hit;
    logic is_bneq;       // early compare in ID
    logic load_use;
    logic branch_load;

    assign ex_wr_valid = dest.ex_reg_w && (dest.ex_rd != '0);
    assign ex_load     = ex_wr_valid && dest.ex_mem_read;
    assign mem_load    = dest.mem_reg_w && dest.mem_mem_read && (dest.mem_rd != '0);

    assign ex_hit_rs1  = (dest.ex_rd == id_rs1_i);
    assign ex_hit_rs2  = (dest.ex_rd == id_rs2_i);
    assign mem_hit     = (dest.mem_rd == id_rs1_i) || (dest.mem_rd == id_rs2_i);

    assign is_bneq     = (id_branch_op_i == BR_BEQ) || (id_branch_op_i == BR_BNE);

    // load data arrives too late for EX, store counts rs1 only
    assign load_use    = ex_load && (ex_hit_rs1 || (!id_is_store_i && ex_hit_rs2));

    // compare in ID needs its operands a stage earlier
    assign branch_load = is_bneq && ((ex_wr_valid && (ex_hit_rs1 || ex_hit_rs2))
                                     || (mem_load && mem_hit));

    assign stall_o     = load_use || branch_load;

endmodule

// ==== design/fwd_ctrl.sv ====
//****************************
// forwarding selects, EX operands and ID compare
//****************************
`timescale 1ns/1ns

module fwd_ctrl import hazard_pkg::*; (
    dest_track_if.dst dest,
    input  reg_addr_t id_rs1_i,    // regs read by ID instr
    input  reg_addr_t id_rs2_i,
    input  reg_addr_t ex_rs1_i,    // regs read by EX instr
    input  reg_addr_t ex_rs2_i,
    output fwd_sel_e  fwd_a_o,     // EX operand a
    output fwd_sel_e  fwd_b_o,     // EX operand b
    output fwd_sel_e  fwd_id_a_o,  // ID compare operand a
    output fwd_sel_e  fwd_id_b_o   // ID compare operand b
);

    // newest producer wins, mem before wb
    function automatic fwd_sel_e pick_src(
        input reg_addr_t rs,
        input logic      mem_w,
        input reg_addr_t mem_rd,
        input logic      wb_w,
        input reg_addr_t wb_rd
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (mem_w && (mem_rd != '0) && (mem_rd == rs))
            sel = FWD_MEM;
        else if (wb_w && (wb_rd != '0) && (wb_rd == rs))
            sel = FWD_WB;
        return sel;
    endfunction

    assign fwd_a_o    = pick_src(ex_rs1_i, dest.mem_reg_w, dest.mem_rd,
                                 dest.wb_reg_w, dest.wb_rd);
    assign fwd_b_o    = pick_src(ex_rs2_i, dest.mem_reg_w, dest.mem_rd,
                                 dest.wb_reg_w, dest.wb_rd);

    // same rule for the early beq/bne compare
    assign fwd_id_a_o = pick_src(id_rs1_i, dest.mem_reg_w, dest.mem_rd,
                                 dest.wb_reg_w, dest.wb_rd);
    assign fwd_id_b_o = pick_src(id_rs2_i, dest.mem_reg_w, dest.mem_rd,
                                 dest.wb_reg_w, dest.wb_rd);

endmodule

// ==== design/dest_track_if.sv ====
//****************************
// dest register state of EX, MEM, WB
//****************************
`timescale 1ns/1ns

interface dest_track_if import hazard_pkg::*; ();
    reg_addr_t ex_rd;        // ID/EX
    logic      ex_reg_w;
    logic      ex_mem_read;  // load in EX
    reg_addr_t mem_rd;       // EX/MEM
    logic      mem_reg_w;
    logic      mem_mem_read; // load in MEM
    reg_addr_t wb_rd;        // MEM/WB
    logic      wb_reg_w;

    modport src (
        output ex_rd, ex_reg_w, ex_mem_read,
        output mem_rd, mem_reg_w, mem_mem_read,
        output wb_rd, wb_reg_w
    );

    modport dst (
        input ex_rd, ex_reg_w, ex_mem_read,
        input mem_rd, mem_reg_w, mem_mem_read,
        input wb_rd, wb_reg_w
    );
endinterface

// ==== design/hazard_pkg.sv ====
//****************************
// hazard unit shared types
//****************************
`include "hazard_macros.svh"

package hazard_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // x0 never forwards or stalls

    // operand source for a forwarding mux
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,  // register file value
        FWD_WB   = 2'b01,  // write-back data
        FWD_MEM  = 2'b10   // alu result in EX/MEM
    } fwd_sel_e;

    // control-flow kind of an instr
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,  // resolved in ID
        BR_BNE  = 4'd2,  // resolved in ID
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JAL  = 4'd7,  // resolved in ID
        BR_JALR = 4'd8   // resolved in EX
    } branch_op_e;

endpackage

// ==== design/hazard_macros.svh ====
//****************************
// hazard unit widths and flush lengths
//****************************
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

`define XLEN            32  // data and address word
`define REG_ADDR_W      5   // x0..x31

// flush cycles after a redirect
`define ID_FLUSH_CYCLES 1   // only IF holds a wrong-path instr
`define EX_FLUSH_CYCLES 2   // IF and ID hold wrong-path instrs

`endif
